/* logic/periph_pkg.sv */
/*
 * Shared definitions for the AHB peripheral subsystem
 * Bus and field widths, timer register map, AHB size and transfer codes,
 * and the byte-lane view of a data word
 */
package periph_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int ADDR_W = 16;  // AHB address
  localparam int DATA_W = 32;  // AHB and APB data
  localparam int SLOT_W = 4;   // Slot select from HADDR[15:12]
  localparam int REG_W  = 10;  // Word offset from HADDR[11:2]

  // ------------------------------
  // Timer register map
  // ------------------------------
  localparam logic [REG_W-1:0] REG_CTRL    = 10'd0;  // [0] enable, [3] irq enable
  localparam logic [REG_W-1:0] REG_VALUE   = 10'd1;  // Current count
  localparam logic [REG_W-1:0] REG_RELOAD  = 10'd2;  // Reload value
  localparam logic [REG_W-1:0] REG_INTSTAT = 10'd3;  // [0] flag, write 1 to clear

  // AHB codes
  localparam logic [2:0] HSIZE_BYTE    = 3'b000;
  localparam logic [2:0] HSIZE_HALF    = 3'b001;
  localparam logic [2:0] HSIZE_WORD    = 3'b010;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;  // Bit 1 also set for SEQ

  // One data word seen as four bytes or as two halfwords
  typedef union packed {
    struct packed {
      logic [7:0] b3;  // Most significant lane
      logic [7:0] b2;
      logic [7:0] b1;
      logic [7:0] b0;
    } bytes;
    struct packed {
      logic [15:0] hi;
      logic [15:0] lo;
    } halves;
  } word_lanes_u;

endpackage

/* logic/ahb_endian_swap.sv */
/*
 * Big-endian byte-lane swap between the AHB bus and the bridge
 * Swap control captured in the address phase, applied to both data paths
 */
module ahb_endian_swap #(
  parameter int BIG_ENDIAN = 0
) (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          i_accept,    // Address phase accepted
  input  logic [2:0]                    i_hsize,
  input  logic [periph_pkg::DATA_W-1:0] i_hwdata,    // From the bus
  input  logic [periph_pkg::DATA_W-1:0] i_rdata_le,  // From the bridge
  output logic [periph_pkg::DATA_W-1:0] o_wdata_le,  // To the bridge
  output logic [periph_pkg::DATA_W-1:0] o_hrdata     // To the bus
);
  import periph_pkg::*;

  logic [1:0] swap_q;    // [1] swap halves, [0] swap bytes in each half
  logic [1:0] swap_nxt;

  // Lane swap through the union views
  function automatic logic [DATA_W-1:0] lane_swap(input logic [DATA_W-1:0] w,
                                                  input logic [1:0]        ctrl);
    word_lanes_u v;
    word_lanes_u t;
    v = w;
    t = v;
    if (ctrl[0])  // Bytes within each half
      t.bytes = {v.bytes.b2, v.bytes.b3, v.bytes.b0, v.bytes.b1};
    v = t;
    if (ctrl[1])  // Upper and lower halves
      t.halves = {v.halves.lo, v.halves.hi};
    return t;
  endfunction

  // Word reverses all four bytes, halfword only inside each half
  always_comb
  begin
    case (i_hsize)
      HSIZE_WORD: swap_nxt = 2'b11;
      HSIZE_HALF: swap_nxt = 2'b01;
      HSIZE_BYTE: swap_nxt = 2'b00;  // Byte lanes already line up
      default:    swap_nxt = 2'b00;
    endcase
    if (BIG_ENDIAN == 0)
      swap_nxt = 2'b00;  // Little endian keeps the lanes as they are
  end

  // Held for the whole data phase
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      swap_q <= 2'b00;
    else if (i_accept)
      swap_q <= swap_nxt;
  end

  assign o_wdata_le = lane_swap(i_hwdata, swap_q);
  assign o_hrdata   = lane_swap(i_rdata_le, swap_q);

endmodule

/* logic/ahb_apb_bridge.sv */
/*
 * AHB-lite to APB bridge
 * Idle, setup and access FSM, slot decode into a one-hot PSEL,
 * registered read data returned in the cycle after the access phase
 */
module ahb_apb_bridge #(
  parameter int NUM_TIMERS = 4
) (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          i_hsel,
  input  logic [periph_pkg::ADDR_W-1:0] i_haddr,
  input  logic [1:0]                    i_htrans,
  input  logic                          i_hwrite,
  input  logic [2:0]                    i_hsize,
  input  logic                          i_hready,
  input  logic [periph_pkg::DATA_W-1:0] i_wdata_le,  // Data phase write data
  input  logic [periph_pkg::DATA_W-1:0] i_prdata,    // Selected slot read data
  output logic                          o_accept,
  output logic                          o_hreadyout,
  output logic [periph_pkg::DATA_W-1:0] o_rdata_le,
  output logic [NUM_TIMERS-1:0]         o_psel,
  output logic [periph_pkg::REG_W-1:0]  o_paddr,
  output logic                          o_penable,
  output logic                          o_pwrite,
  output logic [periph_pkg::DATA_W-1:0] o_pwdata,
  output logic [periph_pkg::SLOT_W-1:0] o_slot
);
  import periph_pkg::*;

  // FSM encoding
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  logic [1:0]        state_q;
  logic [1:0]        state_nxt;
  logic [REG_W-1:0]  addr_q;   // Register offset of the transfer
  logic [SLOT_W-1:0] slot_q;   // Slot of the transfer
  logic              write_q;
  logic [DATA_W-1:0] rdata_q;
  logic              in_xfer;  // Setup or access phase

  // NONSEQ or SEQ with the bus ready
  assign o_accept = i_hsel & i_hready & ((i_htrans & HTRANS_NONSEQ) != 2'b00);

  // ------------------------------
  // FSM
  // ------------------------------
  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      ST_IDLE:
        if (o_accept)
          state_nxt = ST_SETUP;
      ST_SETUP:  state_nxt = ST_ACCESS;
      ST_ACCESS: state_nxt = ST_IDLE;  // No wait states from any slot
      default:   state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q <= ST_IDLE;
      write_q <= 1'b0;
    end
    else
    begin
      state_q <= state_nxt;
      if (state_q == ST_IDLE && o_accept)
        write_q <= i_hwrite;
    end
  end

  // Address phase capture
  always_ff @(posedge HCLK)
  begin
    if (state_q == ST_IDLE && o_accept)
    begin
      addr_q <= i_haddr[REG_W+1:2];
      slot_q <= i_haddr[ADDR_W-1 -: SLOT_W];
    end
  end

  // Read data sampled at the end of the access phase
  always_ff @(posedge HCLK)
  begin
    if (state_q == ST_ACCESS && !write_q)
      rdata_q <= i_prdata;
  end

  assign in_xfer = (state_q == ST_SETUP) || (state_q == ST_ACCESS);

  // Slots without a timer select nothing
  always_comb
  begin
    o_psel = '0;
    for (int i = 0; i < NUM_TIMERS; i++)
      o_psel[i] = in_xfer && (slot_q == SLOT_W'(i));
  end

  assign o_hreadyout = (state_q == ST_IDLE);    // Low for setup and access
  assign o_penable   = (state_q == ST_ACCESS);
  assign o_pwrite    = write_q;
  assign o_paddr     = addr_q;
  assign o_pwdata    = i_wdata_le;  // HWDATA is stable while stalled
  assign o_slot      = slot_q;
  assign o_rdata_le  = rdata_q;

  // The bus holds HREADY low until the current transfer completes
  a_accept_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    o_accept |-> state_q == ST_IDLE);

  // Timers have no byte strobes so every write covers the whole word
  a_word_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
    o_accept && i_hwrite |-> i_hsize == HSIZE_WORD);

endmodule

/* logic/apb_timer.sv */
/*
 * Down-counting APB timer
 * Control, value, reload and interrupt status registers, level interrupt
 */
module apb_timer (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          i_psel,
  input  logic [periph_pkg::REG_W-1:0]  i_paddr,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [periph_pkg::DATA_W-1:0] i_pwdata,
  output logic [periph_pkg::DATA_W-1:0] o_prdata,
  output logic                          o_irq
);
  import periph_pkg::*;

  logic              ctrl_en;   // Count enable
  logic              ctrl_ie;   // Interrupt enable
  logic [DATA_W-1:0] value_q;
  logic [DATA_W-1:0] reload_q;
  logic              int_flag;
  logic              wr_en;     // Write in the access phase
  logic              wrap;      // Count at zero while running

  assign wr_en = i_psel & i_penable & i_pwrite;
  assign wrap  = ctrl_en && (value_q == '0) && !(wr_en && i_paddr == REG_VALUE);

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      ctrl_en  <= 1'b0;
      ctrl_ie  <= 1'b0;
      reload_q <= '0;
    end
    else if (wr_en)
    begin
      if (i_paddr == REG_CTRL)
      begin
        ctrl_en <= i_pwdata[0];
        ctrl_ie <= i_pwdata[3];
      end
      if (i_paddr == REG_RELOAD)
        reload_q <= i_pwdata;
    end
  end

  // Counter, a bus write wins over counting
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      value_q <= '0;
    else if (wr_en && i_paddr == REG_VALUE)
      value_q <= i_pwdata;
    else if (wrap)
      value_q <= reload_q;  // Restart from reload
    else if (ctrl_en)
      value_q <= value_q - 1'b1;
  end

  // Interrupt flag, a new wrap wins over a clear
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      int_flag <= 1'b0;
    else if (wrap)
      int_flag <= 1'b1;
    else if (wr_en && i_paddr == REG_INTSTAT && i_pwdata[0])
      int_flag <= 1'b0;
  end

  // Read mux, sampled by the bridge in the access phase
  always_comb
  begin
    case (i_paddr)
      REG_CTRL:    o_prdata = {{(DATA_W-4){1'b0}}, ctrl_ie, 2'b00, ctrl_en};
      REG_VALUE:   o_prdata = value_q;
      REG_RELOAD:  o_prdata = reload_q;
      REG_INTSTAT: o_prdata = {{(DATA_W-1){1'b0}}, int_flag};
      default:     o_prdata = '0;  // Unused offsets
    endcase
  end

  assign o_irq = int_flag & ctrl_ie;  // Masked level

  // Every access phase to this timer follows its own setup phase
  a_apb_setup: assert property (@(posedge HCLK) disable iff (!HRESETn)
    i_psel && i_penable |-> $past(i_psel && !i_penable));

endmodule

/* logic/apb_return_collector.sv */
/*
 * APB return path
 * Read data mux by slot and optional two-flop interrupt synchronizers
 */
module apb_return_collector #(
  parameter int NUM_TIMERS = 4,
  parameter int SYNC_IRQ   = 0
) (
  input  logic                                          HCLK,
  input  logic                                          HRESETn,
  input  logic [periph_pkg::SLOT_W-1:0]                 i_slot,        // From the bridge
  input  logic [NUM_TIMERS-1:0][periph_pkg::DATA_W-1:0] i_prdata_all,  // One word per timer
  input  logic [NUM_TIMERS-1:0]                         i_irq,
  output logic [periph_pkg::DATA_W-1:0]                 o_prdata,
  output logic [NUM_TIMERS-1:0]                         o_timer_irq
);
  import periph_pkg::*;

  // Slots without a timer read zero
  always_comb
  begin
    o_prdata = '0;
    for (int i = 0; i < NUM_TIMERS; i++)
      if (i_slot == SLOT_W'(i))
        o_prdata = i_prdata_all[i];
  end

  // ------------------------------
  // Interrupt outputs
  // ------------------------------
  generate
    if (SYNC_IRQ != 0)
    begin : g_sync
      logic [NUM_TIMERS-1:0] meta_q;  // First stage
      logic [NUM_TIMERS-1:0] sync_q;  // Second stage

      always_ff @(posedge HCLK or negedge HRESETn)
      begin
        if (!HRESETn)
        begin
          meta_q <= '0;
          sync_q <= '0;
        end
        else
        begin
          meta_q <= i_irq;
          sync_q <= meta_q;
        end
      end

      assign o_timer_irq = sync_q;  // Two cycles behind the timers
    end
    else
    begin : g_direct
      assign o_timer_irq = i_irq;   // Same clock, no delay
    end
  endgenerate

endmodule

/* logic/periph_subsystem.sv */
/*
 * Peripheral subsystem top level
 * Endian swap, AHB to APB bridge, timer array and return collector
 */
module periph_subsystem #(
  parameter int NUM_TIMERS = 4,  // 1 to 15
  parameter int BIG_ENDIAN = 0,
  parameter int SYNC_IRQ   = 0
) (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  logic                          i_hsel,
  input  logic [periph_pkg::ADDR_W-1:0] i_haddr,
  input  logic [1:0]                    i_htrans,
  input  logic                          i_hwrite,
  input  logic [2:0]                    i_hsize,
  input  logic                          i_hready,
  input  logic [periph_pkg::DATA_W-1:0] i_hwdata,
  output logic                          o_hreadyout,
  output logic [periph_pkg::DATA_W-1:0] o_hrdata,
  output logic [NUM_TIMERS-1:0]         o_timer_irq
);
  import periph_pkg::*;

  logic                              accept;
  logic [DATA_W-1:0]                 wdata_le;    // Little-endian write data
  logic [DATA_W-1:0]                 rdata_le;    // Little-endian read data
  logic [NUM_TIMERS-1:0]             psel;
  logic [REG_W-1:0]                  paddr;
  logic                              penable;
  logic                              pwrite;
  logic [DATA_W-1:0]                 pwdata;
  logic [SLOT_W-1:0]                 slot;
  logic [NUM_TIMERS-1:0][DATA_W-1:0] prdata_all;
  logic [NUM_TIMERS-1:0]             irq;         // Raw timer interrupts
  logic [DATA_W-1:0]                 prdata;

  ahb_endian_swap #(.BIG_ENDIAN(BIG_ENDIAN)) u_swap (
    .HCLK(HCLK), .HRESETn(HRESETn), .i_accept(accept), .i_hsize(i_hsize),
    .i_hwdata(i_hwdata), .i_rdata_le(rdata_le),
    .o_wdata_le(wdata_le), .o_hrdata(o_hrdata)
  );

  ahb_apb_bridge #(.NUM_TIMERS(NUM_TIMERS)) u_bridge (
    .HCLK(HCLK), .HRESETn(HRESETn), .i_hsel(i_hsel), .i_haddr(i_haddr),
    .i_htrans(i_htrans), .i_hwrite(i_hwrite), .i_hsize(i_hsize), .i_hready(i_hready),
    .i_wdata_le(wdata_le), .i_prdata(prdata),
    .o_accept(accept), .o_hreadyout(o_hreadyout), .o_rdata_le(rdata_le),
    .o_psel(psel), .o_paddr(paddr), .o_penable(penable), .o_pwrite(pwrite),
    .o_pwdata(pwdata), .o_slot(slot)
  );

  // One timer per slot, shared APB address and data
  for (genvar t = 0; t < NUM_TIMERS; t++)
  begin : g_timer
    apb_timer u_timer (
      .HCLK(HCLK), .HRESETn(HRESETn), .i_psel(psel[t]), .i_paddr(paddr),
      .i_penable(penable), .i_pwrite(pwrite), .i_pwdata(pwdata),
      .o_prdata(prdata_all[t]), .o_irq(irq[t])
    );
  end

  apb_return_collector #(.NUM_TIMERS(NUM_TIMERS), .SYNC_IRQ(SYNC_IRQ)) u_collector (
    .HCLK(HCLK), .HRESETn(HRESETn), .i_slot(slot), .i_prdata_all(prdata_all),
    .i_irq(irq), .o_prdata(prdata), .o_timer_irq(o_timer_irq)
  );

endmodule

/* sim/tb_periph_subsystem.sv */
/*
 * Testbench for the AHB peripheral subsystem
 * Replays the operation list from the test file, checks read data,
 * HREADYOUT stall length and timer interrupt levels
 */
module tb_periph_subsystem;
  import periph_pkg::*;

  localparam int    NUM_TIMERS   = 4;
  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 8;
  localparam int    READY_LIMIT  = 8;    // Stall cycles before a transfer is hung
  localparam int    OP_CYCLES    = 36;   // Longest poll or idle plus overhead
  localparam int    MARGIN       = 100;
  localparam string TEST_FILE    = "sim/periph_tests.txt";

  logic                  HCLK;
  logic                  HRESETn;
  logic                  i_hsel;
  logic [ADDR_W-1:0]     i_haddr;
  logic [1:0]            i_htrans;
  logic                  i_hwrite;
  logic [2:0]            i_hsize;
  logic                  i_hready;
  logic [DATA_W-1:0]     i_hwdata;
  logic                  o_hreadyout;
  logic [DATA_W-1:0]     o_hrdata;
  logic [NUM_TIMERS-1:0] o_timer_irq;

  // Operation list from the test file
  logic [63:0] op_q[$];    // Operation name, packed characters
  logic [31:0] addr_q[$];
  logic [31:0] size_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];

  int     errors      = 0;
  int     checks      = 0;
  int     cycle_cnt   = 0;
  int     cycle_limit = 0;  // Zero until the list is loaded
  integer seed;

  // ------------------------------
  // Clock, watchdog and DUT
  // ------------------------------
  initial
  begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD/2) HCLK = ~HCLK;
  end

  initial
  begin : watchdog
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge HCLK);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
    errors++;
    finish_run();
  end

  periph_subsystem #(.NUM_TIMERS(NUM_TIMERS), .BIG_ENDIAN(1), .SYNC_IRQ(1)) UUT (
    .HCLK(HCLK), .HRESETn(HRESETn), .i_hsel(i_hsel), .i_haddr(i_haddr),
    .i_htrans(i_htrans), .i_hwrite(i_hwrite), .i_hsize(i_hsize), .i_hready(i_hready),
    .i_hwdata(i_hwdata), .o_hreadyout(o_hreadyout), .o_hrdata(o_hrdata),
    .o_timer_irq(o_timer_irq)
  );

  // ------------------------------
  // Tasks
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  endtask

  // Lines starting with # are column notes
  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [63:0] op;
    logic [31:0] a, s, d, e;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0)
      $display("Cannot open the test file %s for reading", TEST_FILE);
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%s %h %h %h %h", op, a, s, d, e);
          if (n == 5)
          begin
            op_q.push_back(op);
            addr_q.push_back(a);
            size_q.push_back(s);
            data_q.push_back(d);
            exp_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Address phase, then data phase until HREADYOUT returns
  task automatic ahb_transfer(input logic [31:0] addr, input logic [31:0] size,
                              input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
    int stall;
    @(posedge HCLK);
    i_hsel   <= 1'b1;
    i_htrans <= HTRANS_NONSEQ;
    i_haddr  <= addr[ADDR_W-1:0];
    i_hwrite <= wr;
    i_hsize  <= size[2:0];
    i_hready <= 1'b1;
    @(posedge HCLK);
    i_hsel   <= 1'b0;  // Bus idle behind this transfer
    i_htrans <= 2'b00;
    i_hwrite <= 1'b0;
    i_hwdata <= wdata;
    stall = 0;
    @(negedge HCLK);
    while (!o_hreadyout && stall < READY_LIMIT)
    begin
      stall++;
      @(negedge HCLK);
    end
    if (!o_hreadyout)
    begin
      $display("Transfer to address %h never completed", addr[ADDR_W-1:0]);
      errors++;
    end
    check_value("o_hreadyout stall cycles", stall, 2);  // Setup and access
    rdata = o_hrdata;
  endtask

  // Wait for one interrupt bit to reach a level
  task automatic poll_irq(input int idx, input int limit, input logic level);
    int waited;
    @(negedge HCLK);
    waited = 1;
    while (o_timer_irq[idx] !== level && waited < limit)
    begin
      @(negedge HCLK);
      waited++;
    end
    check_value($sformatf("o_timer_irq[%0d]", idx), 32'(o_timer_irq[idx]), 32'(level));
  endtask

  // Transfer held off by HREADY low, nothing may start
  task automatic idle_bus(input logic [31:0] addr, input int cycles,
                          input logic [31:0] exp_irq);
    int k;
    @(posedge HCLK);
    i_hsel   <= 1'b1;
    i_htrans <= HTRANS_NONSEQ;
    i_haddr  <= addr[ADDR_W-1:0];
    i_hwrite <= 1'b1;
    i_hsize  <= HSIZE_WORD;
    i_hready <= 1'b0;
    i_hwdata <= $random(seed);
    for (k = 0; k < cycles; k++)
    begin
      @(negedge HCLK);
      check_value("o_hreadyout", 32'(o_hreadyout), 32'd1);
    end
    @(posedge HCLK);
    i_hsel   <= 1'b0;
    i_htrans <= 2'b00;
    i_hwrite <= 1'b0;
    i_hready <= 1'b1;
    @(negedge HCLK);
    check_value("o_timer_irq", 32'(o_timer_irq), exp_irq);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin : main
    logic [31:0] rdata;
    int          i;
    seed     = 32'h7584249b;
    HRESETn  = 1'b0;
    i_hsel   = 1'b0;
    i_haddr  = '0;
    i_htrans = 2'b00;
    i_hwrite = 1'b0;
    i_hsize  = HSIZE_WORD;
    i_hready = 1'b1;
    i_hwdata = '0;
    load_tests();
    if (op_q.size() == 0)
    begin
      $display("No operations were read from the test file");
      errors++;
    end
    else
    begin
      cycle_limit = op_q.size() * OP_CYCLES + RESET_CYCLES + MARGIN;
      repeat (RESET_CYCLES) @(posedge HCLK);
      HRESETn <= 1'b1;
      @(negedge HCLK);
      check_value("o_hreadyout", 32'(o_hreadyout), 32'd1);  // Idle after reset
      check_value("o_timer_irq", 32'(o_timer_irq), 32'd0);
      for (i = 0; i < op_q.size(); i++)
      begin
        if (op_q[i] == "write")
          ahb_transfer(addr_q[i], size_q[i], 1'b1, data_q[i], rdata);
        else if (op_q[i] == "read")
        begin
          ahb_transfer(addr_q[i], size_q[i], 1'b0, 32'h0, rdata);
          check_value($sformatf("o_hrdata at %h", addr_q[i][ADDR_W-1:0]), rdata, exp_q[i]);
        end
        else if (op_q[i] == "poll")
          poll_irq(addr_q[i], data_q[i], exp_q[i][0]);
        else if (op_q[i] == "idle")
          idle_bus(addr_q[i], data_q[i], exp_q[i]);
        else
        begin
          $display("Unknown operation %0s in entry %0d of the test file", op_q[i], i);
          errors++;
        end
      end
      repeat (2) @(posedge HCLK);
    end
    finish_run();
  end

endmodule

/* filelist.f */
logic/periph_pkg.sv
logic/ahb_endian_swap.sv
logic/ahb_apb_bridge.sv
logic/apb_timer.sv
logic/apb_return_collector.sv
logic/periph_subsystem.sv
sim/tb_periph_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it from the project root and
# decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_periph_subsystem \
  -f filelist.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  && grep -qx "All tests passed" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* sim/periph_tests.txt */
# op    addr size data     expected  (hex, data and expected in big-endian bus lane order)
# poll: addr = irq bit, data = cycle limit, expected = level; idle: HREADY low, data = cycles
idle  0004 2 00000004 00000000
read  0004 2 00000000 00000000
write 0008 2 12345678 00000000
read  0008 2 00000000 12345678
write 0004 2 deadbeef 00000000
read  0004 2 00000000 deadbeef
write 1008 2 11223344 00000000
read  1008 1 00000000 33441122
read  1008 0 00000000 44332211
write 2008 2 a5a5f00f 00000000
write 2004 2 0badcafe 00000000
read  1008 2 00000000 11223344
read  1004 2 00000000 00000000
read  2004 2 00000000 0badcafe
read  9004 2 00000000 00000000
read  0014 2 00000000 00000000
write 1008 2 06000000 00000000
write 1004 2 06000000 00000000
write 1000 2 09000000 00000000
poll  0001 2 00000010 00000001
read  100c 2 00000000 01000000
write 1000 2 08000000 00000000
write 100c 2 01000000 00000000
poll  0001 2 00000003 00000000
read  100c 2 00000000 00000000
write 3004 2 03000000 00000000
write 3008 2 03000000 00000000
write 3000 2 01000000 00000000
idle  3004 2 0000000c 00000000
read  300c 2 00000000 01000000
write 3000 2 00000000 00000000
read  1000 2 00000000 08000000
